// ==== source/spu_config.svh ====
`ifndef SPU_CONFIG_SVH
`define SPU_CONFIG_SVH

// operand and result width in bits
`define SPU_DATA_BITS   8

// operands offered on every beat
`define SPU_N           4

// enabled cycles each op spends in its delay line
`define SPU_OP_LATENCY  2

// value loaded into the data slot by a clear beat
`define SPU_CLEAR_DATA  8'h00

`endif

// ==== source/spu_pkg.sv ====
`default_nettype none

`include "spu_config.svh"

package spu_pkg;

    localparam int INSTR_BITS = 8;                  // instruction word width
    localparam int SEL_BITS   = $clog2(`SPU_N);     // operand index width

    typedef logic [`SPU_DATA_BITS-1:0] data_t;
    typedef data_t [`SPU_N-1:0] operands_t;

    typedef enum logic {
        OP_SEL   = 1'b0,
        OP_ARITH = 1'b1
    } op_e;

    // pass one operand through
    typedef struct packed {
        op_e                           op;      // always the top bit
        logic [SEL_BITS-1:0]           idx;
        logic [INSTR_BITS-SEL_BITS-2:0] spare;
    } sel_fmt_t;

    // a +/- b, optionally clamped
    typedef struct packed {
        op_e                             op;    // same bit as in sel_fmt_t
        logic                            sub;   // 1: a - b
        logic                            sat;   // 1: clamp to signed range
        logic [SEL_BITS-1:0]             src_a;
        logic [SEL_BITS-1:0]             src_b;
        logic [INSTR_BITS-2*SEL_BITS-4:0] spare;
    } arith_fmt_t;

    typedef union packed {
        sel_fmt_t   sel;
        arith_fmt_t arith;
    } instr_u;

    typedef struct packed {
        data_t data;
        op_e   op;
    } sel_res_t;

    typedef struct packed {
        logic signed [`SPU_DATA_BITS:0] sum;    // one bit of headroom
        op_e                            op;
        logic                           sat;
    } arith_res_t;

endpackage

`default_nettype wire

// ==== source/spu_op_nop.sv ====
`timescale 1ns/100ps
`default_nettype none

module spu_op_nop #(
    parameter int                   LATENCY    = 1,
    parameter int                   DATA_BITS  = 8,
    parameter logic [DATA_BITS-1:0] CLEAR_DATA = '0
) (
    input  var logic                 clk,
    input  var logic                 reset,
    input  var logic                 cke,

    input  var logic [DATA_BITS-1:0] s_data,
    input  var logic                 s_clear,
    input  var logic                 s_valid,

    output var logic [DATA_BITS-1:0] m_data,
    output var logic                 m_valid
);

    logic [DATA_BITS-1:0] st0_data;
    logic                 st0_valid;

    // a clear beat replaces the payload and counts as valid
    assign st0_data  = s_clear ? CLEAR_DATA : s_data;
    assign st0_valid = s_valid | s_clear;

    if (LATENCY == 0) begin : g_bypass
        assign m_data  = st0_data;
        assign m_valid = st0_valid;
    end else begin : g_pipe
        logic [LATENCY-1:0][DATA_BITS-1:0] data_q;
        logic [LATENCY-1:0]                valid_q;

        always_ff @(posedge clk) begin
            if (reset) begin
                data_q  <= {LATENCY{CLEAR_DATA}};
                valid_q <= '0;
            end else if (cke) begin
                data_q[0]  <= st0_data;
                valid_q[0] <= st0_valid;
                for (int i = 1; i < LATENCY; i++) begin
                    data_q[i]  <= data_q[i-1];      // shift one slot
                    valid_q[i] <= valid_q[i-1];
                end
            end
        end

        assign m_data  = data_q[LATENCY-1];
        assign m_valid = valid_q[LATENCY-1];
    end

endmodule

`default_nettype wire

// ==== source/spu_op_sel.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "spu_config.svh"

module spu_op_sel #(
    parameter int LATENCY = 1
) (
    input  var logic                 clk,
    input  var logic                 reset,
    input  var logic                 cke,

    input  var spu_pkg::operands_t   s_operands,
    input  var spu_pkg::instr_u      s_instr,
    input  var logic                 s_clear,
    input  var logic                 s_valid,

    output var spu_pkg::sel_res_t    m_res,
    output var logic                 m_valid
);

    // clear forces OP_SEL so the merge passes the clear value
    localparam spu_pkg::sel_res_t CLEAR_RES = '{
        data: `SPU_CLEAR_DATA,
        op:   spu_pkg::OP_SEL
    };

    spu_pkg::sel_res_t st0_res;

    assign st0_res.data = s_operands[s_instr.sel.idx];  // select-format view
    assign st0_res.op   = s_instr.sel.op;

    spu_op_nop #(
        .LATENCY    (LATENCY),
        .DATA_BITS  ($bits(spu_pkg::sel_res_t)),
        .CLEAR_DATA (CLEAR_RES)
    ) u_additional_latency (
        .clk        (clk),
        .reset      (reset),
        .cke        (cke),

        .s_data     (st0_res),
        .s_clear    (s_clear),
        .s_valid    (s_valid),

        .m_data     (m_res),
        .m_valid    (m_valid)
    );

endmodule

`default_nettype wire

// ==== source/spu_op_addsub.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "spu_config.svh"

module spu_op_addsub #(
    parameter int LATENCY = 1
) (
    input  var logic                 clk,
    input  var logic                 reset,
    input  var logic                 cke,

    input  var spu_pkg::operands_t   s_operands,
    input  var spu_pkg::instr_u      s_instr,
    input  var logic                 s_clear,
    input  var logic                 s_valid,

    output var spu_pkg::arith_res_t  m_res,
    output var logic                 m_valid
);

    localparam int W = `SPU_DATA_BITS;

    localparam spu_pkg::data_t CLEAR_VALUE = `SPU_CLEAR_DATA;

    // matches the select lane on clear, so the merge picks the clear value
    localparam spu_pkg::arith_res_t CLEAR_RES = '{
        sum: {CLEAR_VALUE[W-1], CLEAR_VALUE},
        op:  spu_pkg::OP_SEL,
        sat: 1'b0
    };

    spu_pkg::data_t      a;
    spu_pkg::data_t      b;
    logic signed [W:0]   a_ext;
    logic signed [W:0]   b_ext;
    spu_pkg::arith_res_t st0_res;

    assign a     = s_operands[s_instr.arith.src_a];    // arithmetic-format view
    assign b     = s_operands[s_instr.arith.src_b];
    assign a_ext = {a[W-1], a};                         // sign extend
    assign b_ext = {b[W-1], b};

    assign st0_res.sum = s_instr.arith.sub ? a_ext - b_ext : a_ext + b_ext;
    assign st0_res.op  = s_instr.arith.op;
    assign st0_res.sat = s_instr.arith.sat;

    spu_op_nop #(
        .LATENCY    (LATENCY),
        .DATA_BITS  ($bits(spu_pkg::arith_res_t)),
        .CLEAR_DATA (CLEAR_RES)
    ) u_additional_latency (
        .clk        (clk),
        .reset      (reset),
        .cke        (cke),

        .s_data     (st0_res),
        .s_clear    (s_clear),
        .s_valid    (s_valid),

        .m_data     (m_res),
        .m_valid    (m_valid)
    );

endmodule

`default_nettype wire

// ==== source/spu_op_merge.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "spu_config.svh"

module spu_op_merge (
    input  var logic                 clk,
    input  var logic                 reset,
    input  var logic                 cke,

    input  var spu_pkg::sel_res_t    s_sel_res,
    input  var logic                 s_sel_valid,
    input  var spu_pkg::arith_res_t  s_arith_res,
    input  var logic                 s_arith_valid,

    output var spu_pkg::data_t       m_data,
    output var logic                 m_valid
);

    localparam int W       = `SPU_DATA_BITS;
    localparam int SAT_MAX = 2**(W-1) - 1;      // 127 for 8 bits
    localparam int SAT_MIN = -(2**(W-1));       // -128

    logic              is_arith;
    logic signed [W:0] sum;
    spu_pkg::data_t    merged;

    // both lanes carry the opcode, and a clear turns both into OP_SEL
    assign is_arith = (s_sel_res.op == spu_pkg::OP_ARITH)
                   && (s_arith_res.op == spu_pkg::OP_ARITH);
    assign sum      = s_arith_res.sum;

    always_comb begin
        if (!is_arith) begin
            merged = s_sel_res.data;
        end else if (s_arith_res.sat && sum > SAT_MAX) begin
            merged = spu_pkg::data_t'(SAT_MAX);     // overflow
        end else if (s_arith_res.sat && sum < SAT_MIN) begin
            merged = spu_pkg::data_t'(SAT_MIN);     // underflow
        end else begin
            merged = sum[W-1:0];                    // wrap
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            m_data  <= `SPU_CLEAR_DATA;
            m_valid <= 1'b0;
        end else if (cke) begin
            m_data  <= merged;
            m_valid <= s_sel_valid & s_arith_valid; // lanes are aligned
        end
    end

endmodule

`default_nettype wire

// ==== source/spu_unit.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "spu_config.svh"

module spu_unit (
    input  var logic                 clk,
    input  var logic                 reset,
    input  var logic                 cke,

    input  var spu_pkg::operands_t   s_operands,
    input  var spu_pkg::instr_u      s_instr,
    input  var logic                 s_clear,
    input  var logic                 s_valid,

    output var spu_pkg::data_t       m_data,
    output var logic                 m_valid
);

    spu_pkg::sel_res_t   sel_res;
    logic                sel_valid;
    spu_pkg::arith_res_t arith_res;
    logic                arith_valid;

    // both ops see every beat
    spu_op_sel #(
        .LATENCY     (`SPU_OP_LATENCY)
    ) u_op_sel (
        .clk         (clk),
        .reset       (reset),
        .cke         (cke),
        .s_operands  (s_operands),
        .s_instr     (s_instr),
        .s_clear     (s_clear),
        .s_valid     (s_valid),
        .m_res       (sel_res),
        .m_valid     (sel_valid)
    );

    spu_op_addsub #(
        .LATENCY     (`SPU_OP_LATENCY)
    ) u_op_addsub (
        .clk         (clk),
        .reset       (reset),
        .cke         (cke),
        .s_operands  (s_operands),
        .s_instr     (s_instr),
        .s_clear     (s_clear),
        .s_valid     (s_valid),
        .m_res       (arith_res),
        .m_valid     (arith_valid)
    );

    spu_op_merge u_op_merge (
        .clk           (clk),
        .reset         (reset),
        .cke           (cke),
        .s_sel_res     (sel_res),
        .s_sel_valid   (sel_valid),
        .s_arith_res   (arith_res),
        .s_arith_valid (arith_valid),
        .m_data        (m_data),
        .m_valid       (m_valid)
    );

endmodule

`default_nettype wire

// ==== sim/spu_unit_assertions.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "spu_config.svh"

module spu_unit_assertions (
    input  var logic                 clk,
    input  var logic                 reset,
    input  var logic                 cke,
    input  var spu_pkg::operands_t   s_operands,
    input  var spu_pkg::instr_u      s_instr,
    input  var logic                 s_clear,
    input  var logic                 s_valid,
    input  var spu_pkg::data_t       m_data,
    input  var logic                 m_valid
);

    localparam int LAT     = `SPU_OP_LATENCY + 1;       // input beat to m_data
    localparam int SAT_MAX = 2**(`SPU_DATA_BITS-1) - 1;
    localparam int SAT_MIN = -(2**(`SPU_DATA_BITS-1));

    int unsigned    fail_count = 0;         // read by the testbench
    spu_pkg::data_t exp_data;
    logic           exp_valid;
    logic           stalled;
    logic [LAT-1:0] run_hist = '0;          // enabled edges, newest in bit 0
    logic [LAT-1:0] rst_hist = '0;          // reset edges, newest in bit 0

    function automatic spu_pkg::data_t expected_out(input spu_pkg::operands_t ops,
                                                    input spu_pkg::instr_u ins,
                                                    input logic clr);
        int a;
        int b;
        int r;
        if (clr) begin
            return `SPU_CLEAR_DATA;
        end
        if (ins.sel.op == spu_pkg::OP_SEL) begin
            return ops[ins.sel.idx];
        end
        a = int'($signed(ops[ins.arith.src_a]));
        b = int'($signed(ops[ins.arith.src_b]));
        r = ins.arith.sub ? a - b : a + b;
        if (ins.arith.sat && r > SAT_MAX) begin
            r = SAT_MAX;
        end else if (ins.arith.sat && r < SAT_MIN) begin
            r = SAT_MIN;
        end
        return spu_pkg::data_t'(r);
    endfunction

    assign exp_data  = expected_out(s_operands, s_instr, s_clear);
    assign exp_valid = s_valid | s_clear;
    assign stalled   = !cke && !reset;

    always @(posedge clk) begin
        run_hist <= {run_hist[LAT-2:0], cke && !reset};
        rst_hist <= {rst_hist[LAT-2:0], reset};
    end

    a_reset_valid: assert property (@(posedge clk) (|rst_hist) |-> !m_valid)
        else begin
            fail_count++;
            $error("CHECK FAILED m_valid got %h expected 0 after reset", $sampled(m_valid));
        end

    a_reset_data: assert property (@(posedge clk) rst_hist[0] |-> m_data == `SPU_CLEAR_DATA)
        else begin
            fail_count++;
            $error("CHECK FAILED m_data got %h expected %h after reset",
                   $sampled(m_data), `SPU_CLEAR_DATA);
        end

    // three enabled edges in a row, so the beat from LAT edges back is at the output
    a_valid: assert property (@(posedge clk) (&run_hist) |-> m_valid == $past(exp_valid, LAT))
        else begin
            fail_count++;
            $error("CHECK FAILED m_valid got %h expected %h",
                   $sampled(m_valid), $past(exp_valid, LAT));
        end

    a_data: assert property (@(posedge clk)
                             (&run_hist && m_valid) |-> m_data == $past(exp_data, LAT))
        else begin
            fail_count++;
            $error("CHECK FAILED m_data got %h expected %h",
                   $sampled(m_data), $past(exp_data, LAT));
        end

    a_stall: assert property (@(posedge clk) $past(stalled) |-> $stable(m_data) && $stable(m_valid))
        else begin
            fail_count++;
            $error("m_data or m_valid changed on an edge where cke was low");
        end

endmodule

`default_nettype wire

// ==== sim/spu_unit_tb.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "spu_config.svh"

module spu_unit_tb;

    localparam int CLK_PERIOD     = 8;
    localparam int RESET_CYCLES   = 4;
    localparam int TIMEOUT_CYCLES = 40;
    localparam int SAT_MAX        = 2**(`SPU_DATA_BITS-1) - 1;
    localparam int SAT_MIN        = -(2**(`SPU_DATA_BITS-1));

    typedef logic [spu_pkg::SEL_BITS-1:0] idx_t;

    logic               clk;
    logic               reset;
    logic               cke;
    spu_pkg::operands_t s_operands;
    spu_pkg::instr_u    s_instr;
    logic               s_clear;
    logic               s_valid;
    spu_pkg::data_t     m_data;
    logic               m_valid;

    int                 seed = 32'hc6ff_aa91;
    int unsigned        tb_errors = 0;
    int unsigned        errs_before = 0;
    int unsigned        tests_run = 0;
    int unsigned        tests_failed = 0;
    int unsigned        out_count = 0;      // output beats seen so far
    logic               upd = 1'b0;         // last edge advanced the pipeline
    logic               track_on = 1'b0;    // queue check active
    spu_pkg::data_t     exp_q[$];

    spu_unit i_dut (
        .clk        (clk),
        .reset      (reset),
        .cke        (cke),
        .s_operands (s_operands),
        .s_instr    (s_instr),
        .s_clear    (s_clear),
        .s_valid    (s_valid),
        .m_data     (m_data),
        .m_valid    (m_valid)
    );

    bind spu_unit spu_unit_assertions u_assertions (
        .clk        (clk),
        .reset      (reset),
        .cke        (cke),
        .s_operands (s_operands),
        .s_instr    (s_instr),
        .s_clear    (s_clear),
        .s_valid    (s_valid),
        .m_data     (m_data),
        .m_valid    (m_valid)
    );

    function automatic spu_pkg::data_t predict(input spu_pkg::operands_t ops,
                                               input spu_pkg::instr_u ins, input logic clr);
        int a;
        int b;
        int r;
        if (clr) begin
            return `SPU_CLEAR_DATA;
        end
        if (ins.sel.op == spu_pkg::OP_SEL) begin
            return ops[ins.sel.idx];
        end
        a = int'($signed(ops[ins.arith.src_a]));
        b = int'($signed(ops[ins.arith.src_b]));
        r = ins.arith.sub ? a - b : a + b;
        if (ins.arith.sat && r > SAT_MAX) begin
            r = SAT_MAX;
        end else if (ins.arith.sat && r < SAT_MIN) begin
            r = SAT_MIN;
        end
        return spu_pkg::data_t'(r);
    endfunction

    function automatic spu_pkg::data_t rand_byte();
        logic [31:0] r;
        r = $random(seed);
        return r[`SPU_DATA_BITS-1:0];
    endfunction

    function automatic spu_pkg::operands_t rand_operands();
        spu_pkg::operands_t ops;
        for (int k = 0; k < `SPU_N; k++) begin
            ops[k] = rand_byte();
        end
        return ops;
    endfunction

    function automatic spu_pkg::instr_u sel_instr(input idx_t idx);
        spu_pkg::instr_u ins;
        ins         = '0;
        ins.sel.op  = spu_pkg::OP_SEL;
        ins.sel.idx = idx;
        return ins;
    endfunction

    function automatic spu_pkg::instr_u arith_instr(input logic sub, input logic sat,
                                                    input idx_t src_a, input idx_t src_b);
        spu_pkg::instr_u ins;
        ins             = '0;
        ins.arith.op    = spu_pkg::OP_ARITH;
        ins.arith.sub   = sub;
        ins.arith.sat   = sat;
        ins.arith.src_a = src_a;
        ins.arith.src_b = src_b;
        return ins;
    endfunction

    function automatic int unsigned total_errors();
        return tb_errors + i_dut.u_assertions.fail_count;
    endfunction

    task automatic drive_beat(input spu_pkg::operands_t ops, input spu_pkg::instr_u ins,
                              input logic clr);
        @(posedge clk);
        #1;
        s_operands = ops;
        s_instr    = ins;
        s_clear    = clr;
        s_valid    = 1'b1;
        if (track_on) begin
            exp_q.push_back(predict(ops, ins, clr));
        end
    endtask

    // clear strobe on its own, s_valid stays low
    task automatic strobe_clear(input spu_pkg::operands_t ops, input spu_pkg::instr_u ins);
        @(posedge clk);
        #1;
        s_operands = ops;
        s_instr    = ins;
        s_clear    = 1'b1;
        s_valid    = 1'b0;
    endtask

    task automatic idle(input int n);
        repeat (n) begin
            @(posedge clk);
            #1;
            s_valid = 1'b0;
            s_clear = 1'b0;
        end
    endtask

    // junk offered while cke is low must never be taken
    task automatic stall(input int n);
        spu_pkg::data_t r;
        repeat (n) begin
            @(posedge clk);
            #1;
            r          = rand_byte();
            cke        = 1'b0;
            s_operands = rand_operands();
            s_instr    = rand_byte();
            s_clear    = r[0];
            s_valid    = 1'b1;
        end
        @(posedge clk);
        #1;
        cke     = 1'b1;
        s_valid = 1'b0;
        s_clear = 1'b0;
    endtask

    task automatic wait_outputs(input int unsigned target);
        int unsigned cycles;
        cycles = 0;
        while (out_count < target && cycles < TIMEOUT_CYCLES) begin
            @(negedge clk);
            cycles++;
        end
        if (out_count < target) begin
            $display("timeout while waiting for m_valid, %0d of %0d beats arrived",
                     out_count, target);
            tb_errors++;
        end
    endtask

    task automatic finish_test(input string name);
        int unsigned errs;
        idle(`SPU_OP_LATENCY + 3);   // let the last checks fire
        errs = total_errors();
        if (errs == errs_before) begin
            $display("test %-10s ok", name);
        end else begin
            $display("test %-10s %0d error(s)", name, errs - errs_before);
            tests_failed++;
        end
        tests_run++;
        errs_before = errs;
    endtask

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD/2) clk = ~clk;
    end

    always @(posedge clk) begin
        upd <= cke && !reset;
    end

    // one beat leaves on each enabled edge that shows m_valid
    always @(negedge clk) begin : collect
        spu_pkg::data_t expected;
        if (upd && m_valid) begin
            out_count++;
            if (track_on) begin
                if (exp_q.size() == 0) begin
                    $display("output beat arrived while no beat was expected");
                    tb_errors++;
                end else begin
                    expected = exp_q.pop_front();
                    assert (m_data === expected) else begin
                        $display("CHECK FAILED m_data got %h expected %h", m_data, expected);
                        tb_errors++;
                    end
                end
            end
        end
    end

    initial begin
        int unsigned        base;
        spu_pkg::data_t     r;
        spu_pkg::operands_t sat_ops;

        reset      = 1'b1;
        cke        = 1'b1;
        s_operands = '0;
        s_instr    = '0;
        s_clear    = 1'b0;
        s_valid    = 1'b0;

        repeat (RESET_CYCLES) begin
            @(posedge clk);
            #1;
            s_operands = rand_operands();   // dropped by reset
            s_instr    = rand_byte();
            s_valid    = 1'b1;
        end
        reset   = 1'b0;
        s_valid = 1'b0;

        base = out_count;
        idle(2);
        drive_beat(rand_operands(), sel_instr(idx_t'(2)), 1'b0);
        idle(1);
        wait_outputs(base + 1);
        finish_test("reset");

        base = out_count;
        for (int i = 0; i < `SPU_N; i++) begin
            drive_beat(rand_operands(), sel_instr(idx_t'(i)), 1'b0);
        end
        idle(1);
        wait_outputs(base + `SPU_N);
        finish_test("select");

        base = out_count;
        repeat (16) begin
            r = rand_byte();
            drive_beat(rand_operands(),
                       arith_instr(r[0], 1'b0, r[1 +: spu_pkg::SEL_BITS],
                                   r[4 +: spu_pkg::SEL_BITS]), 1'b0);
        end
        idle(1);
        wait_outputs(base + 16);
        finish_test("arith wrap");

        sat_ops[0] = spu_pkg::data_t'(SAT_MAX);
        sat_ops[1] = spu_pkg::data_t'(1);
        sat_ops[2] = spu_pkg::data_t'(SAT_MIN);
        sat_ops[3] = spu_pkg::data_t'(-1);
        base = out_count;
        drive_beat(sat_ops, arith_instr(1'b0, 1'b1, 2'd0, 2'd1), 1'b0);  // max + 1
        drive_beat(sat_ops, arith_instr(1'b1, 1'b1, 2'd0, 2'd3), 1'b0);  // max - (-1)
        drive_beat(sat_ops, arith_instr(1'b0, 1'b1, 2'd2, 2'd3), 1'b0);  // min + (-1)
        drive_beat(sat_ops, arith_instr(1'b1, 1'b1, 2'd2, 2'd1), 1'b0);  // min - 1
        drive_beat(sat_ops, arith_instr(1'b1, 1'b1, 2'd0, 2'd2), 1'b0);  // max - min
        drive_beat(sat_ops, arith_instr(1'b1, 1'b1, 2'd2, 2'd0), 1'b0);  // min - max
        drive_beat(sat_ops, arith_instr(1'b0, 1'b1, 2'd1, 2'd3), 1'b0);  // in range
        idle(1);
        wait_outputs(base + 7);
        finish_test("arith sat");

        base = out_count;
        drive_beat(rand_operands(), rand_byte(), 1'b1);
        drive_beat(rand_operands(), sel_instr(idx_t'(1)), 1'b0);
        drive_beat(rand_operands(), arith_instr(1'b0, 1'b1, 2'd0, 2'd1), 1'b1);
        strobe_clear(rand_operands(), arith_instr(1'b1, 1'b1, 2'd2, 2'd1));
        drive_beat(rand_operands(), rand_byte(), 1'b1);
        idle(1);
        wait_outputs(base + 5);
        finish_test("clear");

        track_on = 1'b1;
        base     = out_count;
        drive_beat(rand_operands(), rand_byte(), 1'b0);
        drive_beat(rand_operands(), arith_instr(1'b1, 1'b1, 2'd3, 2'd0), 1'b0);
        drive_beat(rand_operands(), rand_byte(), 1'b1);
        stall(5);
        wait_outputs(base + 3);
        if (exp_q.size() != 0) begin
            $display("%0d beats were lost across the stall", exp_q.size());
            tb_errors++;
        end
        track_on = 1'b0;
        finish_test("stall");

        $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed,
                 total_errors());
        if (total_errors() == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== project.f ====
+incdir+source
source/spu_pkg.sv
source/spu_op_nop.sv
source/spu_op_sel.sv
source/spu_op_addsub.sv
source/spu_op_merge.sv
source/spu_unit.sv
sim/spu_unit_assertions.sv
sim/spu_unit_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the spu_unit testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_DIR=build
LOG=sim.log

rm -rf "$BUILD_DIR"

if ! verilator --binary --timing --assert -f project.f \
        --top-module spu_unit_tb -Mdir "$BUILD_DIR" -o spu_unit_sim; then
    echo "compile failed"
    exit 1
fi

if ! "$BUILD_DIR/spu_unit_sim" +verilator+error+limit+100 > "$LOG" 2>&1; then
    cat "$LOG"
    echo "simulation exited with an error"
    exit 1
fi

cat "$LOG"

if grep -qx "Testbench passed" "$LOG"; then
    exit 0
else
    exit 1
fi
